// ==== hdl/eth_bridge_pkg.sv ====
`default_nettype none

package eth_bridge_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [4:0]  fifo_level_t;

  typedef enum logic {
    SEND_IDLE,
    SEND_WAIT_HDR
  } send_state_t;

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // Word register map
  localparam csr_addr_t REG_MAC_LO      = 5'd0;
  localparam csr_addr_t REG_MAC_HI      = 5'd1;
  localparam csr_addr_t REG_LOCAL_IP    = 5'd2;
  localparam csr_addr_t REG_GATEWAY     = 5'd3;
  localparam csr_addr_t REG_SUBNET      = 5'd4;
  localparam csr_addr_t REG_SEND_IP     = 5'd5;
  localparam csr_addr_t REG_SEND_PORTS  = 5'd6;
  localparam csr_addr_t REG_SEND_LEN    = 5'd7;
  localparam csr_addr_t REG_RECV_IP     = 5'd8;
  localparam csr_addr_t REG_RECV_PORTS  = 5'd9;
  localparam csr_addr_t REG_RECV_LEN    = 5'd10;
  localparam csr_addr_t REG_RECV_MAC_LO = 5'd11;
  localparam csr_addr_t REG_RECV_MAC_HI = 5'd12;
  localparam csr_addr_t REG_CMD         = 5'd13;
  localparam csr_addr_t REG_STATUS      = 5'd14;
  localparam csr_addr_t REG_TX_DATA     = 5'd15;
  localparam csr_addr_t REG_RX_DATA     = 5'd16;

  localparam int CMD_SEND    = 0;
  localparam int CMD_CLR_IRQ = 1;
  localparam int CMD_CLR_RXF = 2;
  localparam int CMD_CLR_TXF = 3;

  localparam int STAT_IRQ_RECV = 0;
  localparam int STAT_IRQ_SENT = 1;
  localparam int STAT_RX_EMPTY = 2;
  localparam int STAT_RX_FULL  = 3;
  localparam int STAT_TX_EMPTY = 4;
  localparam int STAT_TX_FULL  = 5;
  localparam int STAT_RX_LVL   = 8;
  localparam int STAT_TX_LVL   = 16;

  localparam int DATA_LAST_BIT  = 8;
  localparam int DATA_VALID_BIT = 9;

endpackage

`default_nettype wire

// ==== hdl/eth_csr.sv ====
`default_nettype none

module eth_csr
  import eth_bridge_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_csr_wr,
  input  wire              i_csr_rd,
  input  wire csr_addr_t   i_csr_addr,
  input  wire csr_data_t   i_csr_wdata,
  output csr_data_t        o_csr_rdata,
  output logic             o_csr_rvalid,
  stream_if.source         o_tx_push,
  stream_if.sink           i_rx_pop,
  input  wire fifo_level_t i_rx_level,
  input  wire fifo_level_t i_tx_level,
  udp_hdr_if.consumer      i_recv,
  udp_hdr_if.producer      o_send,
  output mac_addr_t        o_local_mac,
  output ip_addr_t         o_local_ip,
  output ip_addr_t         o_gateway_ip,
  output ip_addr_t         o_subnet_mask,
  input  wire              i_irq_recv,
  input  wire              i_irq_sent,
  output logic             o_send_req,
  output logic             o_clr_irq,
  output logic             o_clr_rxf,
  output logic             o_clr_txf
);

  ip_addr_t  send_ip;
  udp_port_t send_src_port;
  udp_port_t send_dst_port;
  udp_len_t  send_len;
  logic      cmd_wr;
  csr_data_t status;
  csr_data_t rdata_next;

  assign cmd_wr     = i_csr_wr && (i_csr_addr == REG_CMD);
  assign o_send_req = cmd_wr && i_csr_wdata[CMD_SEND];
  assign o_clr_irq  = cmd_wr && i_csr_wdata[CMD_CLR_IRQ];
  assign o_clr_rxf  = cmd_wr && i_csr_wdata[CMD_CLR_RXF];
  assign o_clr_txf  = cmd_wr && i_csr_wdata[CMD_CLR_TXF];

  // Data window writes push straight into the tx FIFO which drops them when full
  assign o_tx_push.tvalid = i_csr_wr && (i_csr_addr == REG_TX_DATA);
  assign o_tx_push.tdata  = i_csr_wdata[7:0];
  assign o_tx_push.tlast  = i_csr_wdata[DATA_LAST_BIT];

  assign i_rx_pop.tready = i_csr_rd && (i_csr_addr == REG_RX_DATA);

  // Source MAC of the outgoing frame
  assign o_send.mac      = o_local_mac;
  assign o_send.ip       = send_ip;
  assign o_send.src_port = send_src_port;
  assign o_send.dst_port = send_dst_port;
  assign o_send.length   = send_len;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_local_mac   <= '0;
      o_local_ip    <= '0;
      o_gateway_ip  <= '0;
      o_subnet_mask <= '0;
      send_ip       <= '0;
      send_src_port <= '0;
      send_dst_port <= '0;
      send_len      <= '0;
    end else if (i_csr_wr) begin
      case (i_csr_addr)
        REG_MAC_LO:     o_local_mac[31:0]  <= i_csr_wdata;
        REG_MAC_HI:     o_local_mac[47:32] <= i_csr_wdata[15:0];
        REG_LOCAL_IP:   o_local_ip         <= i_csr_wdata;
        REG_GATEWAY:    o_gateway_ip       <= i_csr_wdata;
        REG_SUBNET:     o_subnet_mask      <= i_csr_wdata;
        REG_SEND_IP:    send_ip            <= i_csr_wdata;
        REG_SEND_PORTS: begin
          send_src_port <= i_csr_wdata[31:16];
          send_dst_port <= i_csr_wdata[15:0];
        end
        REG_SEND_LEN:   send_len           <= i_csr_wdata[15:0];
        default:        ;
      endcase
    end
  end

  always_comb begin
    status = '0;
    status[STAT_IRQ_RECV] = i_irq_recv;
    status[STAT_IRQ_SENT] = i_irq_sent;
    status[STAT_RX_EMPTY] = (i_rx_level == '0);
    status[STAT_RX_FULL]  = (i_rx_level == fifo_level_t'(FIFO_DEPTH));
    status[STAT_TX_EMPTY] = (i_tx_level == '0);
    status[STAT_TX_FULL]  = (i_tx_level == fifo_level_t'(FIFO_DEPTH));
    status[STAT_RX_LVL +: $bits(fifo_level_t)] = i_rx_level;
    status[STAT_TX_LVL +: $bits(fifo_level_t)] = i_tx_level;
  end

  always_comb begin
    rdata_next = '0;
    case (i_csr_addr)
      REG_MAC_LO:      rdata_next = o_local_mac[31:0];
      REG_MAC_HI:      rdata_next[15:0] = o_local_mac[47:32];
      REG_LOCAL_IP:    rdata_next = o_local_ip;
      REG_GATEWAY:     rdata_next = o_gateway_ip;
      REG_SUBNET:      rdata_next = o_subnet_mask;
      REG_SEND_IP:     rdata_next = send_ip;
      REG_SEND_PORTS:  rdata_next = {send_src_port, send_dst_port};
      REG_SEND_LEN:    rdata_next[15:0] = send_len;
      REG_RECV_IP:     rdata_next = i_recv.ip;
      REG_RECV_PORTS:  rdata_next = {i_recv.src_port, i_recv.dst_port};
      REG_RECV_LEN:    rdata_next[15:0] = i_recv.length;
      REG_RECV_MAC_LO: rdata_next = i_recv.mac[31:0];
      REG_RECV_MAC_HI: rdata_next[15:0] = i_recv.mac[47:32];
      REG_STATUS:      rdata_next = status;
      REG_RX_DATA: begin
        if (i_rx_pop.tvalid) begin
          rdata_next[7:0]            = i_rx_pop.tdata;
          rdata_next[DATA_LAST_BIT]  = i_rx_pop.tlast;
          rdata_next[DATA_VALID_BIT] = 1'b1;
        end
      end
      default:         rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_csr_rvalid <= 1'b0;
    end else begin
      o_csr_rvalid <= i_csr_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (i_csr_rd) begin
      o_csr_rdata <= rdata_next;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/eth_udp_bridge.sv ====
`default_nettype none

module eth_udp_bridge
  import eth_bridge_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_csr_wr,
  input  wire              i_csr_rd,
  input  wire csr_addr_t   i_csr_addr,
  input  wire csr_data_t   i_csr_wdata,
  output csr_data_t        o_csr_rdata,
  output logic             o_csr_rvalid,
  input  wire byte_t       i_rx_tdata,
  input  wire              i_rx_tvalid,
  input  wire              i_rx_tlast,
  output logic             o_rx_tready,
  input  wire              i_rx_hdr_valid,
  input  wire mac_addr_t   i_rx_mac,
  input  wire ip_addr_t    i_rx_ip,
  input  wire udp_port_t   i_rx_src_port,
  input  wire udp_port_t   i_rx_dst_port,
  input  wire udp_len_t    i_rx_len,
  output logic             o_tx_hdr_valid,
  input  wire              i_tx_hdr_ready,
  output mac_addr_t        o_tx_mac,
  output ip_addr_t         o_tx_ip,
  output ip_addr_t         o_tx_src_ip,
  output udp_port_t        o_tx_src_port,
  output udp_port_t        o_tx_dst_port,
  output udp_len_t         o_tx_len,
  output byte_t            o_tx_tdata,
  output logic             o_tx_tvalid,
  output logic             o_tx_tlast,
  input  wire              i_tx_tready,
  output mac_addr_t        o_local_mac,
  output ip_addr_t         o_local_ip,
  output ip_addr_t         o_gateway_ip,
  output ip_addr_t         o_subnet_mask,
  output logic             o_pkt_recv,
  output logic             o_pkt_sent
);

  stream_if  rx_in ();
  stream_if  rx_out ();
  stream_if  tx_in ();
  stream_if  tx_out ();
  udp_hdr_if rx_hdr ();
  udp_hdr_if recv_hdr ();
  udp_hdr_if send_hdr ();

  fifo_level_t rx_level;
  fifo_level_t tx_level;
  logic        rx_done;
  logic        tx_done;
  logic        send_req;
  logic        clr_irq;
  logic        clr_rxf;
  logic        clr_txf;

  // Stack payload streams
  assign rx_in.tdata  = i_rx_tdata;
  assign rx_in.tvalid = i_rx_tvalid;
  assign rx_in.tlast  = i_rx_tlast;
  assign o_rx_tready  = rx_in.tready;

  assign o_tx_tdata    = tx_out.tdata;
  assign o_tx_tvalid   = tx_out.tvalid;
  assign o_tx_tlast    = tx_out.tlast;
  assign tx_out.tready = i_tx_tready;

  // Stack header buses
  assign rx_hdr.mac      = i_rx_mac;
  assign rx_hdr.ip       = i_rx_ip;
  assign rx_hdr.src_port = i_rx_src_port;
  assign rx_hdr.dst_port = i_rx_dst_port;
  assign rx_hdr.length   = i_rx_len;

  assign o_tx_mac      = send_hdr.mac;
  assign o_tx_ip       = send_hdr.ip;
  assign o_tx_src_port = send_hdr.src_port;
  assign o_tx_dst_port = send_hdr.dst_port;
  assign o_tx_len      = send_hdr.length;
  assign o_tx_src_ip   = o_local_ip;

  pkt_fifo rx_fifo_i (
    .clk     (clk),
    .rst     (rst),
    .i_wr    (rx_in),
    .o_rd    (rx_out),
    .i_clear (clr_rxf),
    .o_level (rx_level),
    .o_done  (rx_done)
  );

  pkt_fifo tx_fifo_i (
    .clk     (clk),
    .rst     (rst),
    .i_wr    (tx_in),
    .o_rd    (tx_out),
    .i_clear (clr_txf),
    .o_level (tx_level),
    .o_done  (tx_done)
  );

  eth_csr csr_i (
    .clk           (clk),
    .rst           (rst),
    .i_csr_wr      (i_csr_wr),
    .i_csr_rd      (i_csr_rd),
    .i_csr_addr    (i_csr_addr),
    .i_csr_wdata   (i_csr_wdata),
    .o_csr_rdata   (o_csr_rdata),
    .o_csr_rvalid  (o_csr_rvalid),
    .o_tx_push     (tx_in),
    .i_rx_pop      (rx_out),
    .i_rx_level    (rx_level),
    .i_tx_level    (tx_level),
    .i_recv        (recv_hdr),
    .o_send        (send_hdr),
    .o_local_mac   (o_local_mac),
    .o_local_ip    (o_local_ip),
    .o_gateway_ip  (o_gateway_ip),
    .o_subnet_mask (o_subnet_mask),
    .i_irq_recv    (o_pkt_recv),
    .i_irq_sent    (o_pkt_sent),
    .o_send_req    (send_req),
    .o_clr_irq     (clr_irq),
    .o_clr_rxf     (clr_rxf),
    .o_clr_txf     (clr_txf)
  );

  udp_event_ctrl evt_i (
    .clk            (clk),
    .rst            (rst),
    .i_rx_hdr_valid (i_rx_hdr_valid),
    .i_rx_hdr       (rx_hdr),
    .o_recv         (recv_hdr),
    .i_send_req     (send_req),
    .o_tx_hdr_valid (o_tx_hdr_valid),
    .i_tx_hdr_ready (i_tx_hdr_ready),
    .i_rx_done      (rx_done),
    .i_tx_done      (tx_done),
    .i_clr_irq      (clr_irq),
    .o_irq_recv     (o_pkt_recv),
    .o_irq_sent     (o_pkt_sent)
  );

endmodule

`default_nettype wire

// ==== hdl/pkt_fifo.sv ====
`default_nettype none

module pkt_fifo
  import eth_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  stream_if.sink      i_wr,
  stream_if.source    o_rd,
  input  wire         i_clear,
  output fifo_level_t o_level,
  output logic        o_done
);

  // Last flag sits in bit 8 of each entry
  logic [8:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  fifo_level_t        level;
  logic               push;
  logic               pop;

  assign i_wr.tready = (level != fifo_level_t'(FIFO_DEPTH));
  assign push        = i_wr.tvalid && i_wr.tready;

  // Head is shown as soon as it is stored
  assign o_rd.tvalid = (level != '0);
  assign o_rd.tdata  = mem[rd_ptr][7:0];
  assign o_rd.tlast  = mem[rd_ptr][8];
  assign pop         = o_rd.tvalid && o_rd.tready;

  assign o_level = level;
  assign o_done  = pop && o_rd.tlast;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {i_wr.tlast, i_wr.tdata};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  a_level_max: assert property (
    @(posedge clk) disable iff (rst)
    level <= fifo_level_t'(FIFO_DEPTH)
  );

  // Stalled head stays put until the consumer takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    o_rd.tvalid && !o_rd.tready && !i_clear
      |=> o_rd.tvalid && $stable(o_rd.tdata) && $stable(o_rd.tlast)
  );

endmodule

`default_nettype wire

// ==== hdl/stream_if.sv ====
`default_nettype none

interface stream_if
  import eth_bridge_pkg::*;
();

  byte_t tdata;
  logic  tvalid;
  logic  tready;
  logic  tlast;

  modport source (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  modport sink (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

endinterface

`default_nettype wire

// ==== hdl/udp_event_ctrl.sv ====
`default_nettype none

module udp_event_ctrl
  import eth_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         i_rx_hdr_valid,
  udp_hdr_if.consumer i_rx_hdr,
  udp_hdr_if.producer o_recv,
  input  wire         i_send_req,
  output logic        o_tx_hdr_valid,
  input  wire         i_tx_hdr_ready,
  input  wire         i_rx_done,
  input  wire         i_tx_done,
  input  wire         i_clr_irq,
  output logic        o_irq_recv,
  output logic        o_irq_sent
);

  send_state_t state;

  // Header of the last received datagram
  always_ff @(posedge clk) begin
    if (rst) begin
      o_recv.mac      <= '0;
      o_recv.ip       <= '0;
      o_recv.src_port <= '0;
      o_recv.dst_port <= '0;
      o_recv.length   <= '0;
    end else if (i_rx_hdr_valid) begin
      o_recv.mac      <= i_rx_hdr.mac;
      o_recv.ip       <= i_rx_hdr.ip;
      o_recv.src_port <= i_rx_hdr.src_port;
      o_recv.dst_port <= i_rx_hdr.dst_port;
      o_recv.length   <= i_rx_hdr.length;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEND_IDLE;
    end else begin
      case (state)
        SEND_IDLE:     state <= i_send_req ? SEND_WAIT_HDR : SEND_IDLE;
        SEND_WAIT_HDR: state <= i_tx_hdr_ready ? SEND_IDLE : SEND_WAIT_HDR;
        default:       state <= SEND_IDLE;
      endcase
    end
  end

  assign o_tx_hdr_valid = (state == SEND_WAIT_HDR);

  // Clear wins over a set in the same cycle
  always_ff @(posedge clk) begin
    if (rst || i_clr_irq) begin
      o_irq_recv <= 1'b0;
      o_irq_sent <= 1'b0;
    end else begin
      o_irq_recv <= o_irq_recv || i_rx_done;
      o_irq_sent <= o_irq_sent || i_tx_done;
    end
  end

  a_hdr_hold: assert property (
    @(posedge clk) disable iff (rst)
    o_tx_hdr_valid && !i_tx_hdr_ready |=> o_tx_hdr_valid
  );

endmodule

`default_nettype wire

// ==== hdl/udp_hdr_if.sv ====
`default_nettype none

interface udp_hdr_if
  import eth_bridge_pkg::*;
();

  mac_addr_t mac;
  ip_addr_t  ip;
  udp_port_t src_port;
  udp_port_t dst_port;
  udp_len_t  length;

  modport producer (
    output mac,
    output ip,
    output src_port,
    output dst_port,
    output length
  );

  modport consumer (
    input mac,
    input ip,
    input src_port,
    input dst_port,
    input length
  );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f vlog.f --top-module tb_eth_udp_bridge -o tb_eth_udp_bridge
sim_out=$(./obj_dir/tb_eth_udp_bridge)
echo "$sim_out"
if echo "$sim_out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

// ==== verification/tb_host_tasks.svh ====
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Drive point just after the rising edge
task automatic step();
  @(posedge clk);
  #2;
endtask

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

task automatic reg_write(input csr_addr_t addr, input csr_data_t data);
  i_csr_wr    = 1'b1;
  i_csr_addr  = addr;
  i_csr_wdata = data;
  step();
  i_csr_wr    = 1'b0;
endtask

// Queues the expected word for the read checker and waits for the reply
task automatic reg_read_expect(input csr_addr_t addr, input csr_data_t exp,
                               input csr_data_t mask, input string name);
  exp_q.push_back(exp);
  mask_q.push_back(mask);
  name_q.push_back(name);
  reads_issued++;
  i_csr_rd   = 1'b1;
  i_csr_addr = addr;
  step();
  i_csr_rd   = 1'b0;
  // Reply is due exactly one cycle after the strobe
  @(negedge clk);
  check_value("o_csr_rvalid", 64'(o_csr_rvalid), 64'(1));
  @(posedge clk);
  while (reads_done != reads_issued) begin
    @(posedge clk);
  end
  #2;
endtask

// Holds the byte until the receive FIFO takes it
task automatic drive_rx_byte(input byte_t data, input logic last);
  i_rx_tdata  = data;
  i_rx_tlast  = last;
  i_rx_tvalid = 1'b1;
  @(negedge clk);
  while (!o_rx_tready) begin
    @(negedge clk);
  end
  step();
  i_rx_tvalid = 1'b0;
  i_rx_tlast  = 1'b0;
endtask

task automatic finish_test(input string name, input int err_start);
  tests_run++;
  if (errors == err_start) begin
    $display("%s: ok", name);
  end else begin
    tests_failed++;
    $display("%s: failed with %0d errors", name, errors - err_start);
  end
endtask

`endif

// ==== verification/tb_eth_udp_bridge.sv ====
`default_nettype none

module tb_eth_udp_bridge
  import eth_bridge_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // Far above the roughly 150 cycles the five tests need
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] SEED = 32'h473bb790;

  logic      clk;
  logic      rst;
  logic      i_csr_wr;
  logic      i_csr_rd;
  csr_addr_t i_csr_addr;
  csr_data_t i_csr_wdata;
  csr_data_t o_csr_rdata;
  logic      o_csr_rvalid;
  byte_t     i_rx_tdata;
  logic      i_rx_tvalid;
  logic      i_rx_tlast;
  logic      o_rx_tready;
  logic      i_rx_hdr_valid;
  mac_addr_t i_rx_mac;
  ip_addr_t  i_rx_ip;
  udp_port_t i_rx_src_port;
  udp_port_t i_rx_dst_port;
  udp_len_t  i_rx_len;
  logic      o_tx_hdr_valid;
  logic      i_tx_hdr_ready;
  mac_addr_t o_tx_mac;
  ip_addr_t  o_tx_ip;
  ip_addr_t  o_tx_src_ip;
  udp_port_t o_tx_src_port;
  udp_port_t o_tx_dst_port;
  udp_len_t  o_tx_len;
  byte_t     o_tx_tdata;
  logic      o_tx_tvalid;
  logic      o_tx_tlast;
  logic      i_tx_tready;
  mac_addr_t o_local_mac;
  ip_addr_t  o_local_ip;
  ip_addr_t  o_gateway_ip;
  ip_addr_t  o_subnet_mask;
  logic      o_pkt_recv;
  logic      o_pkt_sent;

  logic [31:0] seed;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          reads_issued = 0;
  int          reads_done = 0;
  int          cycle_count = 0;
  csr_data_t   exp_q[$];
  csr_data_t   mask_q[$];
  string       name_q[$];
  logic        tx_check_en;
  logic [31:0] tx_base;
  int          tx_count;

  eth_udp_bridge dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = lcg_step(seed);
    return seed;
  endfunction

  // Byte idx of a payload that starts from base
  function automatic byte_t ref_byte(input logic [31:0] base, input int idx);
    logic [31:0] s;
    int          n;
    s = base;
    for (n = 0; n <= idx; n++) begin
      s = lcg_step(s);
    end
    return s[23:16];
  endfunction

  function automatic csr_data_t ref_status(input int rx_lvl, input int tx_lvl,
                                           input logic irq_r, input logic irq_s);
    csr_data_t s;
    s = '0;
    s[STAT_IRQ_RECV] = irq_r;
    s[STAT_IRQ_SENT] = irq_s;
    s[STAT_RX_EMPTY] = (rx_lvl == 0);
    s[STAT_RX_FULL]  = (rx_lvl == FIFO_DEPTH);
    s[STAT_TX_EMPTY] = (tx_lvl == 0);
    s[STAT_TX_FULL]  = (tx_lvl == FIFO_DEPTH);
    s[STAT_RX_LVL +: $bits(fifo_level_t)] = fifo_level_t'(rx_lvl);
    s[STAT_TX_LVL +: $bits(fifo_level_t)] = fifo_level_t'(tx_lvl);
    return s;
  endfunction

  // Register reads compared while o_csr_rvalid is settled
  always @(negedge clk) begin : read_check
    csr_data_t exp_word;
    csr_data_t mask;
    string     name;
    if (o_csr_rvalid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("A register read returned data that no test asked for");
      end else begin
        exp_word = exp_q.pop_front();
        mask     = mask_q.pop_front();
        name     = name_q.pop_front();
        check_value(name, 64'(o_csr_rdata & mask), 64'(exp_word & mask));
        reads_done++;
      end
    end
  end

  // Transmit payload bytes in order as the stack accepts them
  always @(negedge clk) begin
    if (!tx_check_en) begin
      tx_count = 0;
    end else if (o_tx_tvalid && i_tx_tready) begin
      check_value("o_tx_tdata", 64'(o_tx_tdata), 64'(ref_byte(tx_base, tx_count)));
      check_value("o_tx_tlast", 64'(o_tx_tlast), 64'(tx_count == 7));
      tx_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests were still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    mac_addr_t   mac;
    ip_addr_t    ip;
    ip_addr_t    gw;
    ip_addr_t    mask;
    mac_addr_t   rmac;
    ip_addr_t    rip;
    udp_port_t   rsport;
    udp_port_t   rdport;
    ip_addr_t    sip;
    udp_port_t   sport;
    udp_port_t   dport;
    logic [31:0] r;
    logic [31:0] base;
    int          err_start;
    int          accepted;
    int          i;

    rst            = 1'b1;
    i_csr_wr       = 1'b0;
    i_csr_rd       = 1'b0;
    i_csr_addr     = '0;
    i_csr_wdata    = '0;
    i_rx_tdata     = '0;
    i_rx_tvalid    = 1'b0;
    i_rx_tlast     = 1'b0;
    i_rx_hdr_valid = 1'b0;
    i_rx_mac       = '0;
    i_rx_ip        = '0;
    i_rx_src_port  = '0;
    i_rx_dst_port  = '0;
    i_rx_len       = '0;
    i_tx_hdr_ready = 1'b0;
    i_tx_tready    = 1'b0;
    tx_check_en    = 1'b0;
    tx_base        = '0;
    seed           = SEED;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    step();

    err_start = errors;
    r = next_rand();
    mac[47:32] = r[15:0];
    mac[31:0]  = next_rand();
    ip   = next_rand();
    gw   = next_rand();
    mask = next_rand();
    reg_write(REG_MAC_LO, mac[31:0]);
    reg_write(REG_MAC_HI, {16'h0, mac[47:32]});
    reg_write(REG_LOCAL_IP, ip);
    reg_write(REG_GATEWAY, gw);
    reg_write(REG_SUBNET, mask);
    reg_read_expect(REG_MAC_LO, mac[31:0], '1, "o_csr_rdata (MAC_LO)");
    reg_read_expect(REG_MAC_HI, {16'h0, mac[47:32]}, '1, "o_csr_rdata (MAC_HI)");
    reg_read_expect(REG_LOCAL_IP, ip, '1, "o_csr_rdata (LOCAL_IP)");
    reg_read_expect(REG_GATEWAY, gw, '1, "o_csr_rdata (GATEWAY)");
    reg_read_expect(REG_SUBNET, mask, '1, "o_csr_rdata (SUBNET)");
    @(negedge clk);
    check_value("o_local_mac", 64'(o_local_mac), 64'(mac));
    check_value("o_local_ip", 64'(o_local_ip), 64'(ip));
    check_value("o_gateway_ip", 64'(o_gateway_ip), 64'(gw));
    check_value("o_subnet_mask", 64'(o_subnet_mask), 64'(mask));
    step();
    finish_test("configuration", err_start);

    err_start = errors;
    r = next_rand();
    rmac[47:32] = r[15:0];
    rmac[31:0]  = next_rand();
    rip = next_rand();
    r = next_rand();
    rsport = r[31:16];
    rdport = r[15:0];
    i_rx_mac       = rmac;
    i_rx_ip        = rip;
    i_rx_src_port  = rsport;
    i_rx_dst_port  = rdport;
    i_rx_len       = 16'd10;
    i_rx_hdr_valid = 1'b1;
    step();
    i_rx_hdr_valid = 1'b0;
    base = next_rand();
    for (i = 0; i < 10; i++) begin
      drive_rx_byte(ref_byte(base, i), i == 9);
    end
    reg_read_expect(REG_RECV_IP, rip, '1, "o_csr_rdata (RECV_IP)");
    reg_read_expect(REG_RECV_PORTS, {rsport, rdport}, '1, "o_csr_rdata (RECV_PORTS)");
    reg_read_expect(REG_RECV_LEN, 32'd10, '1, "o_csr_rdata (RECV_LEN)");
    reg_read_expect(REG_RECV_MAC_LO, rmac[31:0], '1, "o_csr_rdata (RECV_MAC_LO)");
    reg_read_expect(REG_RECV_MAC_HI, {16'h0, rmac[47:32]}, '1, "o_csr_rdata (RECV_MAC_HI)");
    for (i = 0; i < 10; i++) begin
      reg_read_expect(REG_RX_DATA, {22'h0, 1'b1, i == 9, ref_byte(base, i)}, '1,
                      "o_csr_rdata (RX_DATA)");
    end
    @(negedge clk);
    check_value("o_pkt_recv", 64'(o_pkt_recv), 64'(1));
    step();
    reg_read_expect(REG_STATUS, ref_status(0, 0, 1'b1, 1'b0), '1, "o_csr_rdata (STATUS)");
    reg_write(REG_CMD, csr_data_t'(1 << CMD_CLR_IRQ));
    @(negedge clk);
    check_value("o_pkt_recv", 64'(o_pkt_recv), 64'(0));
    step();
    finish_test("receive path", err_start);

    err_start = errors;
    tx_base = next_rand();
    for (i = 0; i < 8; i++) begin
      reg_write(REG_TX_DATA, {23'h0, i == 7, ref_byte(tx_base, i)});
    end
    sip = next_rand();
    r = next_rand();
    sport = r[31:16];
    dport = r[15:0];
    reg_write(REG_SEND_IP, sip);
    reg_write(REG_SEND_PORTS, {sport, dport});
    reg_write(REG_SEND_LEN, 32'd8);
    reg_read_expect(REG_STATUS, ref_status(0, 8, 1'b0, 1'b0), '1, "o_csr_rdata (STATUS)");
    tx_check_en = 1'b1;
    reg_write(REG_CMD, csr_data_t'(1 << CMD_SEND));
    // Header waits while the stack is not ready
    repeat (3) begin
      @(negedge clk);
      check_value("o_tx_hdr_valid", 64'(o_tx_hdr_valid), 64'(1));
      check_value("o_tx_mac", 64'(o_tx_mac), 64'(mac));
      check_value("o_tx_ip", 64'(o_tx_ip), 64'(sip));
      check_value("o_tx_src_ip", 64'(o_tx_src_ip), 64'(ip));
      check_value("o_tx_src_port", 64'(o_tx_src_port), 64'(sport));
      check_value("o_tx_dst_port", 64'(o_tx_dst_port), 64'(dport));
      check_value("o_tx_len", 64'(o_tx_len), 64'(8));
      step();
    end
    i_tx_hdr_ready = 1'b1;
    @(negedge clk);
    check_value("o_tx_hdr_valid", 64'(o_tx_hdr_valid), 64'(1));
    step();
    i_tx_hdr_ready = 1'b0;
    @(negedge clk);
    check_value("o_tx_hdr_valid", 64'(o_tx_hdr_valid), 64'(0));
    step();
    while (tx_count < 8) begin
      r = next_rand();
      i_tx_tready = r[16];
      step();
    end
    i_tx_tready = 1'b0;
    tx_check_en = 1'b0;
    @(negedge clk);
    check_value("o_pkt_sent", 64'(o_pkt_sent), 64'(1));
    check_value("o_tx_tvalid", 64'(o_tx_tvalid), 64'(0));
    step();
    finish_test("transmit path", err_start);

    err_start = errors;
    base = next_rand();
    accepted = 0;
    for (i = 0; i < 20; i++) begin
      i_rx_tdata  = ref_byte(base, i);
      i_rx_tvalid = 1'b1;
      @(negedge clk);
      if (o_rx_tready) begin
        accepted++;
      end
      step();
    end
    i_rx_tvalid = 1'b0;
    check_value("rx bytes accepted", 64'(accepted), 64'(FIFO_DEPTH));
    @(negedge clk);
    check_value("o_rx_tready", 64'(o_rx_tready), 64'(0));
    step();
    reg_read_expect(REG_STATUS, ref_status(16, 0, 1'b0, 1'b1), '1, "o_csr_rdata (STATUS)");
    finish_test("back-pressure", err_start);

    err_start = errors;
    for (i = 0; i < 3; i++) begin
      reg_write(REG_TX_DATA, {24'h0, ref_byte(base, i)});
    end
    reg_read_expect(REG_STATUS, ref_status(16, 3, 1'b0, 1'b1), '1, "o_csr_rdata (STATUS)");
    reg_write(REG_CMD, csr_data_t'((1 << CMD_CLR_RXF) | (1 << CMD_CLR_TXF)));
    reg_read_expect(REG_STATUS, ref_status(0, 0, 1'b0, 1'b1), '1, "o_csr_rdata (STATUS)");
    reg_read_expect(REG_RX_DATA, '0, csr_data_t'(1 << DATA_VALID_BIT),
                    "o_csr_rdata (RX_DATA valid)");
    finish_test("FIFO clears", err_start);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  `include "tb_host_tasks.svh"

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
hdl/eth_bridge_pkg.sv
hdl/stream_if.sv
hdl/udp_hdr_if.sv
hdl/pkt_fifo.sv
hdl/eth_csr.sv
hdl/udp_event_ctrl.sv
hdl/eth_udp_bridge.sv
verification/tb_eth_udp_bridge.sv
